// ==== compile.f ====
verilog/pd_pkg.sv
verilog/sample_delay.sv
verilog/conj_mult.sv
verilog/window_sum.sv
verilog/mag_estimate.sv
verilog/sts_decision.sv
verilog/ofdm_packet_detect.sv
test/tb_clock.sv
test/tb_ofdm_packet_detect.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the packet detect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_ofdm_packet_detect \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== test/tb_clock.sv ====
// testbench clock and reset

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // held over the first rising edges, dropped on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== test/tb_ofdm_packet_detect.sv ====
// packet detect testbench

`timescale 1ns/1ps

module tb_ofdm_packet_detect import pd_pkg::*; ();

    localparam int SEQ_LEN       = 16;
    // sample driven in cycle c shows as a pulse in cycle c+12
    localparam int LATENCY       = 12;
    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 100;

    logic                clk;
    logic                rst;
    logic                enable_i;
    cplx_sample_t        sample_i;
    logic                sample_valid_i;
    logic [THRESH_W-1:0] sts_threshold_i;
    logic                sts_detect_o;

    integer       seed = 32'heab8_cf2f;
    int           errors = 0;
    int           checks = 0;
    int           ungapped_count = 0;
    longint       cyc = 0;
    longint       last_drive_cyc = 0;
    longint       expected_q[$];
    longint       observed_q[$];
    cplx_sample_t stream_q[$];

    // reference model state, index 0 newest
    longint line_i [SEQ_LEN];
    longint line_q [SEQ_LEN];
    longint xp_i   [SEQ_LEN];
    longint xp_q   [SEQ_LEN];
    longint ap_i   [SEQ_LEN];
    int     run_len;
    int     model_thresh;

    tb_clock u_clock (.clk_o (clk), .rst_o (rst));

    ofdm_packet_detect #(.DELAY_LEN (SEQ_LEN), .WIN_LEN (SEQ_LEN)) dut (
        .clk             (clk),
        .rst             (rst),
        .enable_i        (enable_i),
        .sample_i        (sample_i),
        .sample_valid_i  (sample_valid_i),
        .sts_threshold_i (sts_threshold_i),
        .sts_detect_o    (sts_detect_o)
    );

    // cycle index, read on falling edges only
    always @(posedge clk) cyc <= cyc + 1;

    // log every cycle that carries the detect flag
    always @(negedge clk) begin
        if (sts_detect_o) observed_q.push_back(cyc);
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic longint mag_of(input longint re, input longint im);
        longint a;
        longint b;
        a = (re < 0) ? -re : re;
        b = (im < 0) ? -im : im;
        // larger part plus a truncated quarter of the smaller
        return (a > b) ? a + (b >> 2) : b + (a >> 2);
    endfunction

    task automatic model_reset();
        for (int k = 0; k < SEQ_LEN; k++) begin
            line_i[k] = 0;
            line_q[k] = 0;
            xp_i[k]   = 0;
            xp_q[k]   = 0;
            ap_i[k]   = 0;
        end
        run_len = 0;
    endtask

    task automatic model_step(input cplx_sample_t s, output bit pulse);
        longint di;
        longint dq;
        longint ci;
        longint cq;
        longint sxi;
        longint sxq;
        longint sai;
        longint level;
        di = line_i[SEQ_LEN-1];
        dq = line_q[SEQ_LEN-1];
        ci = s.i;
        cq = s.q;
        for (int k = SEQ_LEN - 1; k > 0; k--) begin
            line_i[k] = line_i[k-1];
            line_q[k] = line_q[k-1];
            xp_i[k]   = xp_i[k-1];
            xp_q[k]   = xp_q[k-1];
            ap_i[k]   = ap_i[k-1];
        end
        line_i[0] = ci;
        line_q[0] = cq;
        // conj(d)*c, and conj(c)*c which is purely real
        xp_i[0] = di * ci + dq * cq;
        xp_q[0] = di * cq - dq * ci;
        ap_i[0] = ci * ci + cq * cq;
        sxi = 0;
        sxq = 0;
        sai = 0;
        for (int k = 0; k < SEQ_LEN; k++) begin
            sxi += xp_i[k];
            sxq += xp_q[k];
            sai += ap_i[k];
        end
        // 75 % as truncated quarter plus truncated half
        level = (mag_of(sai, 0) >> 2) + (mag_of(sai, 0) >> 1);
        pulse = 1'b0;
        if (mag_of(sxi, sxq) <= level) begin
            run_len = 0;
        end else if (run_len == model_thresh) begin
            pulse = 1'b1;
            run_len = 0;
        end else begin
            run_len++;
        end
    endtask

    // ======================================================================
    // checking and stimulus helpers
    // ======================================================================
    task automatic check_value(input string what, input longint exp_v, input longint act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("FAIL at %0t: %s, expected %0d, observed %0d", $time, what, exp_v, act_v);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic clear_dut(input int thresh);
        @(negedge clk);
        enable_i        = 1'b0;
        sample_valid_i  = 1'b0;
        sample_i        = '0;
        sts_threshold_i = THRESH_W'(thresh);
        repeat (2) @(negedge clk);
        enable_i     = 1'b1;
        model_thresh = thresh;
        model_reset();
        expected_q.delete();
        observed_q.delete();
    endtask

    task automatic drive_sample(input cplx_sample_t s);
        bit pulse;
        @(negedge clk);
        sample_i       = s;
        sample_valid_i = 1'b1;
        model_step(s, pulse);
        if (pulse) expected_q.push_back(cyc + LATENCY);
        last_drive_cyc = cyc;
    endtask

    task automatic drive_stream(input int first, input int count, input int max_gap);
        int gap;
        for (int k = first; k < first + count; k++) begin
            drive_sample(stream_q[k]);
            if (max_gap > 0) begin
                gap = 1 + int'({$random(seed)} % max_gap);
                repeat (gap) begin
                    @(negedge clk);
                    sample_valid_i = 1'b0;
                end
            end
        end
    endtask

    // idle until the last sample has had time to reach the flag
    task automatic drain_pipeline();
        int guard;
        guard = 0;
        @(negedge clk);
        sample_valid_i = 1'b0;
        sample_i       = '0;
        while (cyc <= last_drive_cyc + LATENCY + 2 && guard < DRAIN_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (cyc <= last_drive_cyc + LATENCY + 2) report_timeout("pipeline did not drain");
    endtask

    task automatic compare_pulses(input string name);
        check_value({name, " pulse count"}, expected_q.size(), observed_q.size());
        for (int k = 0; k < expected_q.size() && k < observed_q.size(); k++) begin
            check_value({name, " pulse cycle"}, expected_q[k], observed_q[k]);
        end
    endtask

    function automatic int count_between(input longint lo, input longint hi);
        int n;
        n = 0;
        foreach (observed_q[k]) begin
            if (observed_q[k] > lo && observed_q[k] <= hi) n++;
        end
        return n;
    endfunction

    task automatic finish_test(input string name, input int err0);
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic idle_after_reset();
        int err0;
        err0 = errors;
        clear_dut(5);
        repeat (100) drive_sample('0);
        drain_pipeline();
        check_value("pulses on zero input", 0, observed_q.size());
        compare_pulses("idle");
        finish_test("idle_after_reset", err0);
    endtask

    task automatic periodic_detection();
        int err0;
        err0 = errors;
        clear_dut(5);
        drive_stream(0, 160, 0);
        drain_pipeline();
        check_value("periodic pulses seen", 1, observed_q.size() > 1);
        // one unbroken run, so a pulse every T+1 windows
        for (int k = 1; k < observed_q.size(); k++) begin
            check_value("periodic pulse spacing", model_thresh + 1,
                        observed_q[k] - observed_q[k-1]);
        end
        compare_pulses("periodic");
        ungapped_count = expected_q.size();
        finish_test("periodic_detection", err0);
    endtask

    task automatic zero_threshold();
        int err0;
        err0 = errors;
        clear_dut(0);
        drive_stream(0, 160, 0);
        drain_pipeline();
        compare_pulses("zero threshold");
        finish_test("zero_threshold", err0);
    endtask

    task automatic gapped_valid();
        int err0;
        err0 = errors;
        clear_dut(5);
        drive_stream(0, 160, 3);
        drain_pipeline();
        check_value("gapped count vs ungapped", ungapped_count, observed_q.size());
        compare_pulses("gapped");
        finish_test("gapped_valid", err0);
    endtask

    task automatic enable_clears();
        int     err0;
        longint off_start;
        longint off_end;
        err0 = errors;
        clear_dut(5);
        drive_stream(0, 80, 0);
        drain_pipeline();
        @(negedge clk);
        enable_i  = 1'b0;
        off_start = cyc;
        // offered while disabled, so dropped by the DUT and the model
        for (int k = 80; k < 100; k++) begin
            @(negedge clk);
            sample_i       = stream_q[k];
            sample_valid_i = 1'b1;
        end
        @(negedge clk);
        sample_valid_i = 1'b0;
        enable_i       = 1'b1;
        off_end        = cyc;
        model_reset();
        drive_stream(100, 60, 0);
        drain_pipeline();
        check_value("pulses while disabled", 0, count_between(off_start, off_end));
        compare_pulses("enable");
        finish_test("enable_clears", err0);
    endtask

    task automatic random_noise();
        int           err0;
        cplx_sample_t s;
        err0 = errors;
        stream_q.delete();
        // 14-bit amplitudes keep every product inside 32 bits
        repeat (300) begin
            s.i = SAMPLE_W'($random(seed) % 8192);
            s.q = SAMPLE_W'($random(seed) % 8192);
            stream_q.push_back(s);
        end
        clear_dut(20);
        drive_stream(0, 300, 0);
        drain_pipeline();
        compare_pulses("noise");
        finish_test("random_noise", err0);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        cplx_sample_t period [SEQ_LEN];
        int           guard;
        enable_i        = 1'b0;
        sample_i        = '0;
        sample_valid_i  = 1'b0;
        sts_threshold_i = '0;
        guard           = 0;
        @(negedge clk);
        while (rst && guard < RESET_TIMEOUT) begin
            @(negedge clk);
            guard++;
        end
        if (rst) report_timeout("reset was never released");
        // one random training period, repeated
        for (int k = 0; k < SEQ_LEN; k++) begin
            period[k].i = SAMPLE_W'($random(seed) % 8192);
            period[k].q = SAMPLE_W'($random(seed) % 8192);
        end
        for (int k = 0; k < 160; k++) stream_q.push_back(period[k % SEQ_LEN]);
        idle_after_reset();
        periodic_detection();
        zero_threshold();
        gapped_valid();
        enable_clears();
        random_noise();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/conj_mult.sv ====
// conjugate complex multiplier

`timescale 1ns/1ps

module conj_mult import pd_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         enable_i,
    input  cplx_sample_t a_i,
    input  cplx_sample_t b_i,
    input  logic         valid_i,
    output cplx_prod_t   prod_o,
    output logic         valid_o
);

    // stage 1, conj(a) with one extra bit so -(-32768) stays exact
    logic signed [SAMPLE_W-1:0] a_re_q;
    logic signed [SAMPLE_W:0]   a_qn_q;
    cplx_sample_t               b_q;
    logic                       v1_q;

    // stage 2, partial products
    logic signed [2*SAMPLE_W:0] pp_ii_q;
    logic signed [2*SAMPLE_W:0] pp_qq_q;
    logic signed [2*SAMPLE_W:0] pp_iq_q;
    logic signed [2*SAMPLE_W:0] pp_qi_q;
    logic                       v2_q;

    // ==================================================================
    // pipeline
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            a_re_q  <= '0;
            a_qn_q  <= '0;
            b_q     <= '0;
            v1_q    <= 1'b0;
            pp_ii_q <= '0;
            pp_qq_q <= '0;
            pp_iq_q <= '0;
            pp_qi_q <= '0;
            v2_q    <= 1'b0;
            prod_o  <= '0;
            valid_o <= 1'b0;
        end else begin
            a_re_q  <= a_i.i;
            a_qn_q  <= -((SAMPLE_W+1)'(a_i.q));
            b_q     <= b_i;
            v1_q    <= valid_i;
            // (ar + j*aqn) * (br + j*bq)
            pp_ii_q <= a_re_q * b_q.i;
            pp_qq_q <= a_qn_q * b_q.q;
            pp_iq_q <= a_re_q * b_q.q;
            pp_qi_q <= a_qn_q * b_q.i;
            v2_q    <= v1_q;
            // wraps only when both operands hold the most negative value
            prod_o.i <= PROD_W'(pp_ii_q - pp_qq_q);
            prod_o.q <= PROD_W'(pp_iq_q + pp_qi_q);
            valid_o  <= v2_q;
        end
    end

    // strobe is the input pattern three cycles late, cleared by rst or enable low
    logic live;
    assign live = enable_i && !rst;

    a_valid_pipe: assert property (@(posedge clk) disable iff (rst)
        valid_o == ($past(valid_i && live, 3) && $past(live, 2) && $past(live, 1)));

endmodule

// ==== verilog/mag_estimate.sv ====
// complex magnitude estimate

`timescale 1ns/1ps

module mag_estimate import pd_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable_i,
    input  cplx_sum_t        sum_i,
    input  logic             valid_i,
    output logic [MAG_W-1:0] mag_o,
    output logic             valid_o
);

    // |-2^(SUM_W-1)| still fits unsigned in SUM_W bits
    logic [SUM_W-1:0] abs_i_q;
    logic [SUM_W-1:0] abs_q_q;
    logic             v1_q;

    logic [SUM_W-1:0] max_q;
    logic [SUM_W-1:0] min_q;
    logic             v2_q;

    // ==================================================================
    // mag ~ max(|I|,|Q|) + min(|I|,|Q|)/4
    // ==================================================================
    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            abs_i_q <= '0;
            abs_q_q <= '0;
            v1_q    <= 1'b0;
            max_q   <= '0;
            min_q   <= '0;
            v2_q    <= 1'b0;
            mag_o   <= '0;
            valid_o <= 1'b0;
        end else begin
            // stage 1, absolute values
            v1_q <= valid_i;
            if (valid_i) begin
                abs_i_q <= sum_i.i[SUM_W-1] ? SUM_W'(-sum_i.i) : SUM_W'(sum_i.i);
                abs_q_q <= sum_i.q[SUM_W-1] ? SUM_W'(-sum_i.q) : SUM_W'(sum_i.q);
            end
            // stage 2, order the pair
            v2_q <= v1_q;
            if (v1_q) begin
                max_q <= (abs_i_q > abs_q_q) ? abs_i_q : abs_q_q;
                min_q <= (abs_i_q > abs_q_q) ? abs_q_q : abs_i_q;
            end
            // stage 3, gated by its own stage valid
            valid_o <= v2_q;
            if (v2_q) begin
                mag_o <= MAG_W'(max_q) + MAG_W'(min_q >> 2);
            end
        end
    end

endmodule

// ==== verilog/ofdm_packet_detect.sv ====
// 802.11a packet detect top

`timescale 1ns/1ps

// valid sample in cycle n gives sts_detect_o in cycle n+12
// 1 delay, 3 mult, 2 window, 3 magnitude, 3 decision
module ofdm_packet_detect import pd_pkg::*; #(
    parameter int DELAY_LEN = STS_LEN,
    parameter int WIN_LEN   = STS_LEN
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable_i,
    input  cplx_sample_t        sample_i,
    input  logic                sample_valid_i,
    input  logic [THRESH_W-1:0] sts_threshold_i,
    output logic                sts_detect_o
);

    // ==================================================================
    // delay line, aligned delayed and current samples
    // ==================================================================
    cplx_sample_t delayed;
    cplx_sample_t current;
    logic         dly_valid;

    sample_delay #(
        .DELAY_LEN (DELAY_LEN),
        .payload_t (cplx_sample_t)
    ) u_delay (
        .clk       (clk),
        .rst       (rst),
        .enable_i  (enable_i),
        .data_i    (sample_i),
        .valid_i   (sample_valid_i),
        .delayed_o (delayed),
        .current_o (current),
        .valid_o   (dly_valid)
    );

    // ==================================================================
    // cross path, conj(s[n-16]) * s[n]
    // ==================================================================
    cplx_prod_t       cross_prod;
    logic             cross_prod_valid;
    cplx_sum_t        cross_sum;
    logic             cross_sum_valid;
    logic [MAG_W-1:0] cross_mag;
    logic             cross_mag_valid;

    conj_mult u_mult_cross (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .a_i (delayed), .b_i (current), .valid_i (dly_valid),
        .prod_o (cross_prod), .valid_o (cross_prod_valid)
    );

    window_sum #(.WIN_LEN (WIN_LEN)) u_win_cross (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .prod_i (cross_prod), .valid_i (cross_prod_valid),
        .sum_o (cross_sum), .valid_o (cross_sum_valid)
    );

    mag_estimate u_mag_cross (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .sum_i (cross_sum), .valid_i (cross_sum_valid),
        .mag_o (cross_mag), .valid_o (cross_mag_valid)
    );

    // ==================================================================
    // auto path, conj(s[n]) * s[n]
    // ==================================================================
    cplx_prod_t       auto_prod;
    logic             auto_prod_valid;
    cplx_sum_t        auto_sum;
    logic             auto_sum_valid;
    logic [MAG_W-1:0] auto_mag;
    logic             auto_mag_valid;

    conj_mult u_mult_auto (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .a_i (current), .b_i (current), .valid_i (dly_valid),
        .prod_o (auto_prod), .valid_o (auto_prod_valid)
    );

    window_sum #(.WIN_LEN (WIN_LEN)) u_win_auto (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .prod_i (auto_prod), .valid_i (auto_prod_valid),
        .sum_o (auto_sum), .valid_o (auto_sum_valid)
    );

    mag_estimate u_mag_auto (
        .clk (clk), .rst (rst), .enable_i (enable_i),
        .sum_i (auto_sum), .valid_i (auto_sum_valid),
        .mag_o (auto_mag), .valid_o (auto_mag_valid)
    );

    // both paths run in lockstep, one shared strobe
    sts_decision u_decision (
        .clk         (clk),
        .rst         (rst),
        .enable_i    (enable_i),
        .cross_mag_i (cross_mag),
        .auto_mag_i  (auto_mag),
        .valid_i     (cross_mag_valid && auto_mag_valid),
        .threshold_i (sts_threshold_i),
        .detect_o    (sts_detect_o)
    );

endmodule

// ==== verilog/pd_pkg.sv ====
// packet detect shared types

package pd_pkg;

    // ==================================================================
    // widths
    // ==================================================================
    // one I or Q input component
    localparam int SAMPLE_W = 16;
    // one component of conj(a)*b
    localparam int PROD_W   = 32;
    // window sum, product plus log2 of the window
    localparam int SUM_W    = 36;
    // max + min/4 needs one more bit than the sum
    localparam int MAG_W    = 37;
    // detect threshold and run counter
    localparam int THRESH_W = 16;

    // short training symbol period in samples
    localparam int STS_LEN  = 16;

    // ==================================================================
    // complex types
    // ==================================================================
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } cplx_sample_t;

    typedef struct packed {
        logic signed [PROD_W-1:0] i;
        logic signed [PROD_W-1:0] q;
    } cplx_prod_t;

    typedef struct packed {
        logic signed [SUM_W-1:0] i;
        logic signed [SUM_W-1:0] q;
    } cplx_sum_t;

endpackage

// ==== verilog/sample_delay.sv ====
// one period sample delay line

`timescale 1ns/1ps

module sample_delay import pd_pkg::*; #(
    parameter int  DELAY_LEN = STS_LEN,
    parameter type payload_t = cplx_sample_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable_i,
    input  payload_t data_i,
    input  logic     valid_i,
    output payload_t delayed_o,
    output payload_t current_o,
    output logic     valid_o
);

    // slot 0 holds the newest sample, last slot the oldest
    payload_t slot_q [DELAY_LEN];

    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            // empty line reads as zero
            for (int k = 0; k < DELAY_LEN; k++) begin
                slot_q[k] <= '0;
            end
            delayed_o <= '0;
            current_o <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // advance only on real samples, gaps leave the line alone
            if (valid_i) begin
                slot_q[0] <= data_i;
                for (int k = 1; k < DELAY_LEN; k++) begin
                    slot_q[k] <= slot_q[k-1];
                end
                // tap read before the shift, so DELAY_LEN samples back
                delayed_o <= slot_q[DELAY_LEN-1];
                current_o <= data_i;
            end
        end
    end

    // output strobe only ever follows an accepted input one cycle back
    a_valid_follows_input: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> $past(valid_i && enable_i && !rst));

endmodule

// ==== verilog/sts_decision.sv ====
// short training sequence decision

`timescale 1ns/1ps

module sts_decision import pd_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable_i,
    input  logic [MAG_W-1:0]    cross_mag_i,
    input  logic [MAG_W-1:0]    auto_mag_i,
    input  logic                valid_i,
    input  logic [THRESH_W-1:0] threshold_i,
    output logic                detect_o
);

    logic [THRESH_W-1:0] thresh_q;
    // stage 1, cross magnitude and the 75 % level
    logic [MAG_W-1:0]    cross_q;
    logic [MAG_W-1:0]    level_q;
    logic                v1_q;
    // stage 2, compare result
    logic                qual_q;
    logic                v2_q;
    // consecutive qualifying windows so far
    logic [THRESH_W-1:0] run_q;
    logic                hit;

    // run has reached the programmed length on a qualifying window
    assign hit = v2_q && qual_q && (run_q == thresh_q);

    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            thresh_q <= '0;
            cross_q  <= '0;
            level_q  <= '0;
            v1_q     <= 1'b0;
            qual_q   <= 1'b0;
            v2_q     <= 1'b0;
            run_q    <= '0;
            detect_o <= 1'b0;
        end else begin
            thresh_q <= threshold_i;
            v1_q     <= valid_i;
            if (valid_i) begin
                cross_q <= cross_mag_i;
                // quarter plus half, each truncated
                level_q <= (auto_mag_i >> 2) + (auto_mag_i >> 1);
            end
            v2_q <= v1_q;
            if (v1_q) begin
                qual_q <= cross_q > level_q;
            end
            if (v2_q) begin
                if (!qual_q || hit) begin
                    run_q <= '0;
                end else begin
                    run_q <= run_q + 1'b1;
                end
            end
            detect_o <= hit;
        end
    end

    // after a pulse the run restarts at zero, so no back-to-back pulses
    a_no_double_pulse: assert property (@(posedge clk) disable iff (rst)
        (detect_o && thresh_q != '0) |=> !detect_o);

endmodule

// ==== verilog/window_sum.sv ====
// sliding window complex sum

`timescale 1ns/1ps

module window_sum import pd_pkg::*; #(
    parameter int WIN_LEN = STS_LEN
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable_i,
    input  cplx_prod_t prod_i,
    input  logic       valid_i,
    output cplx_sum_t  sum_o,
    output logic       valid_o
);

    // last WIN_LEN products, slot 0 newest
    cplx_prod_t hist_q [WIN_LEN];
    cplx_sum_t  acc_q;
    logic       v1_q;

    // one extra bit to catch growth beyond SUM_W
    logic signed [SUM_W:0] next_i;
    logic signed [SUM_W:0] next_q;

    // add newest, drop the one falling out of the window
    always_comb begin
        next_i = acc_q.i + prod_i.i - hist_q[WIN_LEN-1].i;
        next_q = acc_q.q + prod_i.q - hist_q[WIN_LEN-1].q;
    end

    always_ff @(posedge clk) begin
        if (rst || !enable_i) begin
            // unfilled slots count as zero products
            for (int k = 0; k < WIN_LEN; k++) begin
                hist_q[k] <= '0;
            end
            acc_q   <= '0;
            v1_q    <= 1'b0;
            sum_o   <= '0;
            valid_o <= 1'b0;
        end else begin
            v1_q <= valid_i;
            if (valid_i) begin
                hist_q[0] <= prod_i;
                for (int k = 1; k < WIN_LEN; k++) begin
                    hist_q[k] <= hist_q[k-1];
                end
                acc_q.i <= next_i[SUM_W-1:0];
                acc_q.q <= next_q[SUM_W-1:0];
            end
            // output register, second cycle of latency
            valid_o <= v1_q;
            if (v1_q) begin
                sum_o <= acc_q;
            end
        end
    end

    // running sum never leaves the SUM_W range
    a_sum_in_range: assert property (@(posedge clk) disable iff (rst || !enable_i)
        valid_i |-> (next_i[SUM_W] == next_i[SUM_W-1]) && (next_q[SUM_W] == next_q[SUM_W-1]));

endmodule
